//--- hw/tx_pack_pkg.sv
// Transmit packer definitions
package tx_pack_pkg;

   // ----------------------------------------------------------------------
   // widths
   // ----------------------------------------------------------------------
   localparam int DESC_W = 128;
   localparam int DATA_W = 64;
   localparam int LEN_W  = 10;

   // descriptor field positions
   localparam int FMT_PAYLOAD_BIT = 126;
   localparam int FMT_4DW_BIT     = 125;
   localparam int LEN_LSB         = 96;
   // address low bits sit in dword 2 for 3dw, dword 3 for 4dw
   localparam int ADDR3_LSB       = 32;
   localparam int ADDR4_LSB       = 0;
   localparam int QW_BITS         = 3;

   // ----------------------------------------------------------------------
   // beat FIFO sizing
   // ----------------------------------------------------------------------
   localparam int FIFO_DEPTH = 32;
   localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
   // requests and payload held off above this fill level
   localparam int FIFO_AFULL = 16;

   typedef logic [DESC_W-1:0]  desc_t;
   typedef logic [DATA_W-1:0]  data_t;
   typedef logic [LEN_W-1:0]   dw_len_t;
   typedef logic [FIFO_AW:0]   fifo_cnt_t;

   // stored beat is {err, sop, eop, data}
   typedef logic [DATA_W+2:0]  beat_t;
   localparam int BEAT_ERR = DATA_W + 2;
   localparam int BEAT_SOP = DATA_W + 1;
   localparam int BEAT_EOP = DATA_W;

   // request control states
   typedef enum logic [1:0] {
      IDLE,
      HDR_WAIT,
      PAYLOAD
   } ctrl_state_t;

endpackage

//--- hw/tx_hdr_if.sv
// Decoded header attributes
`timescale 1ns/1ns

interface tx_hdr_if;
   import tx_pack_pkg::*;

   // header size and payload flags
   logic    is_3dw;
   logic    has_payload;
   logic    qw_aligned;
   // payload dword count, zero for dataless headers
   dw_len_t length;
   // 3dw, unaligned, with payload: word 0 rides in header beat 1
   logic    merge_first;

   modport src (
      output is_3dw, has_payload, qw_aligned, length, merge_first
   );

   modport dst (
      input is_3dw, has_payload, qw_aligned, length, merge_first
   );

endinterface

//--- hw/tx_beat_if.sv
// Framed beat to the beat FIFO
`timescale 1ns/1ns

interface tx_beat_if;
   import tx_pack_pkg::*;

   // single cycle write strobe, no back-pressure
   logic  wr;
   data_t data;
   // start and end of packet marks
   logic  sop;
   logic  eop;
   // poisoned packet mark
   logic  err;

   modport src (
      output wr, data, sop, eop, err
   );

   modport dst (
      input wr, data, sop, eop, err
   );

endinterface

//--- hw/tx_req_ctrl.sv
// Request and wait-state control
`timescale 1ns/1ns

module tx_req_ctrl (
   input  logic                  clk_in,
   input  logic                  srst,
   input  logic                  tx_req,
   input  logic                  tx_dv,
   input  logic                  tx_dfr,
   input  tx_pack_pkg::fifo_cnt_t fifo_cnt,
   input  logic                  fifo_empty,
   tx_hdr_if.dst                 hdr,
   output logic                  first_req,
   output logic                  tx_ack,
   output logic                  tx_ws,
   output logic                  data_take
);
   import tx_pack_pkg::*;

   ctrl_state_t state;
   ctrl_state_t state_nxt;
   logic        req_q;
   logic        afull_r;
   logic        req_pend;
   logic        hold_hdr;

   // rising edge of the request level
   assign first_req = tx_req & ~req_q;

   // request latch lives in HDR_WAIT, cleared by the ack
   assign req_pend = (state == HDR_WAIT);

   // merged header needs word 0 present in the ack cycle
   assign tx_ack = req_pend & ~afull_r & (~hdr.merge_first | tx_dv);

   // 4dw or aligned: payload waits until both header beats are written
   assign hold_hdr = req_pend & ~(hdr.is_3dw & ~hdr.qw_aligned);
   // first request cycle also holds data off, attributes not yet settled
   assign tx_ws = afull_r | first_req | hold_hdr;

   // ----------------------------------------------------------------------
   // payload accept and state transitions
   // ----------------------------------------------------------------------
   always_comb begin
      data_take = 1'b0;
      state_nxt = state;
      case (state)
         IDLE: begin
            if (first_req) begin
               state_nxt = HDR_WAIT;
            end
         end
         HDR_WAIT: begin
            // only the merged header takes a word here
            data_take = tx_ack & hdr.merge_first;
            if (tx_ack) begin
               if (!hdr.has_payload || (data_take && !tx_dfr)) begin
                  state_nxt = IDLE;
               end else begin
                  state_nxt = PAYLOAD;
               end
            end
         end
         PAYLOAD: begin
            data_take = tx_dv & ~afull_r;
            // dfr low marks the last word
            if (data_take && !tx_dfr) begin
               state_nxt = IDLE;
            end
         end
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk_in) begin
      if (srst) begin
         state   <= IDLE;
         req_q   <= 1'b0;
         afull_r <= 1'b0;
      end else begin
         state   <= state_nxt;
         req_q   <= tx_req;
         afull_r <= (fifo_cnt > fifo_cnt_t'(FIFO_AFULL)) & ~fifo_empty;
      end
   end

   // source keeps tx_req high until it sees the ack
   a_ack_has_req: assert property (@(posedge clk_in) disable iff (srst)
      tx_ack |-> tx_req)
      else $error("tx_ack without pending request");

   // state based accept must agree with the external wait state
   a_take_no_ws: assert property (@(posedge clk_in) disable iff (srst)
      data_take |-> !tx_ws)
      else $error("payload taken while tx_ws high");

endmodule

//--- hw/tx_hdr_decode.sv
// Descriptor decoder
`timescale 1ns/1ns

module tx_hdr_decode (
   input  logic               clk_in,
   input  logic               srst,
   input  logic               first_req,
   input  tx_pack_pkg::desc_t tx_desc,
   tx_hdr_if.src              hdr
);
   import tx_pack_pkg::*;

   logic                dec_3dw;
   logic                dec_payload;
   logic                dec_aligned;
   logic [QW_BITS-1:0]  dec_addr;
   dw_len_t             dec_len;

   logic                is_3dw_r;
   logic                has_payload_r;
   logic                qw_aligned_r;
   dw_len_t             length_r;

   // format bits
   assign dec_3dw     = ~tx_desc[FMT_4DW_BIT];
   assign dec_payload = tx_desc[FMT_PAYLOAD_BIT];
   // low address bits depend on header size
   assign dec_addr    = dec_3dw ? tx_desc[ADDR3_LSB +: QW_BITS] :
                                  tx_desc[ADDR4_LSB +: QW_BITS];
   assign dec_aligned = (dec_addr == '0);
   // length only counts when a payload follows
   assign dec_len     = dec_payload ? tx_desc[LEN_LSB +: LEN_W] : '0;

   // capture on the first request cycle, hold until the next one
   always_ff @(posedge clk_in) begin
      if (srst) begin
         is_3dw_r      <= 1'b0;
         has_payload_r <= 1'b0;
         qw_aligned_r  <= 1'b0;
         length_r      <= '0;
      end else if (first_req) begin
         is_3dw_r      <= dec_3dw;
         has_payload_r <= dec_payload;
         qw_aligned_r  <= dec_aligned;
         length_r      <= dec_len;
      end
   end

   // forward the fresh decode during the first request cycle
   assign hdr.is_3dw      = first_req ? dec_3dw     : is_3dw_r;
   assign hdr.has_payload = first_req ? dec_payload : has_payload_r;
   assign hdr.qw_aligned  = first_req ? dec_aligned : qw_aligned_r;
   assign hdr.length      = first_req ? dec_len     : length_r;
   assign hdr.merge_first = hdr.is_3dw & ~hdr.qw_aligned & hdr.has_payload;

endmodule

//--- hw/tx_beat_packer.sv
// Header and payload beat packer
`timescale 1ns/1ns

module tx_beat_packer (
   input  logic               clk_in,
   input  logic               first_req,
   input  logic               tx_ack,
   input  logic               data_take,
   input  logic               tx_dfr,
   input  logic               tx_err,
   input  tx_pack_pkg::desc_t tx_desc,
   input  tx_pack_pkg::data_t tx_data,
   tx_hdr_if.dst              hdr,
   tx_beat_if.src             beat
);
   import tx_pack_pkg::*;

   data_t beat_d;
   logic  wr_d;
   logic  sop_d;
   logic  eop_d;
   logic  eop_hdr;
   logic  eop_data;

   data_t data_r;
   logic  wr_r;
   logic  sop_r;
   logic  eop_r;
   logic  err_r;

   // ----------------------------------------------------------------------
   // beat data select
   // ----------------------------------------------------------------------
   //   beat 0     H0 H1
   //   beat 1     H2 H3, or H2 D0 for the merged header
   //   payload    dwords swapped, low dword goes first on the link
   always_comb begin
      if (first_req) begin
         beat_d = tx_desc[DESC_W-1 -: DATA_W];
      end else if (tx_ack) begin
         if (hdr.merge_first) begin
            beat_d = {tx_desc[DATA_W-1 -: DATA_W/2], tx_data[DATA_W-1 -: DATA_W/2]};
         end else begin
            beat_d = tx_desc[DATA_W-1:0];
         end
      end else begin
         beat_d = {tx_data[DATA_W/2-1:0], tx_data[DATA_W-1 -: DATA_W/2]};
      end
   end

   // one write per header phase or accepted word
   // merged word 0 shares the ack cycle, so no second write
   assign wr_d  = first_req | tx_ack | data_take;
   assign sop_d = first_req;

   // ----------------------------------------------------------------------
   // end of packet
   // ----------------------------------------------------------------------
   // dataless header, or merged header carrying its only dword
   assign eop_hdr  = tx_ack & (~hdr.has_payload |
                               (hdr.merge_first & (hdr.length == dw_len_t'(1))));
   // last payload word accepted
   assign eop_data = data_take & ~tx_dfr;
   assign eop_d    = eop_hdr | eop_data;

   // single register stage into the FIFO
   always_ff @(posedge clk_in) begin
      wr_r   <= wr_d;
      data_r <= beat_d;
      sop_r  <= sop_d;
      eop_r  <= eop_d;
      // source holds tx_err for the whole packet
      err_r  <= tx_err;
   end

   assign beat.wr   = wr_r;
   assign beat.data = data_r;
   assign beat.sop  = sop_r;
   assign beat.eop  = eop_r;
   assign beat.err  = err_r;

endmodule

//--- hw/tx_beat_fifo.sv
// Synchronous beat FIFO
`timescale 1ns/1ns

module tx_beat_fifo #(
   parameter int DEPTH_LOG2 = tx_pack_pkg::FIFO_AW
) (
   input  logic                   clk_in,
   input  logic                   srst,
   tx_beat_if.dst                 beat,
   input  logic                   rd,
   output tx_pack_pkg::beat_t     q,
   output logic                   empty,
   output tx_pack_pkg::fifo_cnt_t cnt
);
   import tx_pack_pkg::*;

   localparam int DEPTH = 1 << DEPTH_LOG2;

   beat_t                 mem [DEPTH];
   logic [DEPTH_LOG2-1:0] wptr;
   logic [DEPTH_LOG2-1:0] rptr;
   fifo_cnt_t             cnt_r;
   logic                  full;
   logic                  wr_en;
   logic                  rd_en;
   beat_t                 wr_word;

   // field order follows BEAT_ERR, BEAT_SOP, BEAT_EOP
   assign wr_word = {beat.err, beat.sop, beat.eop, beat.data};

   assign full  = (cnt_r == fifo_cnt_t'(DEPTH));
   assign empty = (cnt_r == '0);
   assign cnt   = cnt_r;

   assign wr_en = beat.wr & ~full;
   assign rd_en = rd & ~empty;

   // pointers and fill count
   always_ff @(posedge clk_in) begin
      if (srst) begin
         wptr  <= '0;
         rptr  <= '0;
         cnt_r <= '0;
      end else begin
         if (wr_en) begin
            wptr <= wptr + 1'b1;
         end
         if (rd_en) begin
            rptr <= rptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   cnt_r <= cnt_r + 1'b1;
            2'b01:   cnt_r <= cnt_r - 1'b1;
            default: cnt_r <= cnt_r;
         endcase
      end
   end

   // storage and registered read port
   always_ff @(posedge clk_in) begin
      if (wr_en) begin
         mem[wptr] <= wr_word;
      end
      if (rd_en) begin
         q <= mem[rptr];
      end
   end

   // almost-full throttle upstream must keep room for in-flight beats
   a_no_overflow: assert property (@(posedge clk_in) disable iff (srst)
      beat.wr |-> !full)
      else $error("beat FIFO write while full");

   a_no_underflow: assert property (@(posedge clk_in) disable iff (srst)
      rd |-> !empty)
      else $error("beat FIFO read while empty");

endmodule

//--- hw/tx_stream_out.sv
// Streaming output stage
`timescale 1ns/1ns

module tx_stream_out (
   input  logic               clk_in,
   input  logic               srst,
   input  tx_pack_pkg::beat_t q,
   input  logic               empty,
   output logic               rd,
   input  logic               tx_stream_ready,
   output tx_pack_pkg::data_t tx_stream_data,
   output logic               tx_stream_sop,
   output logic               tx_stream_eop,
   output logic               tx_stream_err,
   output logic               tx_stream_valid
);
   import tx_pack_pkg::*;

   beat_t out_r;
   logic  out_valid;
   // FIFO q holds a read beat not yet moved out
   logic  q_vld;
   logic  load;

   // move q into the output register when it is free or draining
   assign load = q_vld & (~out_valid | tx_stream_ready);
   // a new read may overwrite q only once it has moved on
   assign rd   = ~empty & (~q_vld | load);

   always_ff @(posedge clk_in) begin
      if (srst) begin
         q_vld     <= 1'b0;
         out_valid <= 1'b0;
      end else begin
         q_vld     <= rd | (q_vld & ~load);
         out_valid <= load | (out_valid & ~tx_stream_ready);
      end
   end

   always_ff @(posedge clk_in) begin
      if (load) begin
         out_r <= q;
      end
   end

   // split the stored beat into port fields
   assign tx_stream_data  = out_r[DATA_W-1:0];
   assign tx_stream_sop   = out_r[BEAT_SOP];
   assign tx_stream_eop   = out_r[BEAT_EOP];
   assign tx_stream_err   = out_r[BEAT_ERR];
   assign tx_stream_valid = out_valid;

   a_hold_on_stall: assert property (@(posedge clk_in) disable iff (srst)
      tx_stream_valid && !tx_stream_ready |=> tx_stream_valid && $stable(tx_stream_data))
      else $error("output beat changed while stalled");

endmodule

//--- hw/tx_pack_top.sv
// Transmit packer top level
`timescale 1ns/1ns

module tx_pack_top (
   input  logic               clk_in,
   input  logic               srst,
   // request port
   input  logic               tx_req,
   output logic               tx_ack,
   input  tx_pack_pkg::desc_t tx_desc,
   output logic               tx_ws,
   // payload source
   input  logic               tx_err,
   input  logic               tx_dv,
   input  logic               tx_dfr,
   input  tx_pack_pkg::data_t tx_data,
   // streaming link
   input  logic               tx_stream_ready,
   output tx_pack_pkg::data_t tx_stream_data,
   output logic               tx_stream_sop,
   output logic               tx_stream_eop,
   output logic               tx_stream_err,
   output logic               tx_stream_valid,
   output logic               tx_fifo_empty
);
   import tx_pack_pkg::*;

   logic      first_req;
   logic      data_take;
   fifo_cnt_t fifo_cnt;
   logic      fifo_rd;
   beat_t     fifo_q;

   tx_hdr_if  hdr_if ();
   tx_beat_if beat_if ();

   // ----------------------------------------------------------------------
   // request side
   // ----------------------------------------------------------------------
   tx_req_ctrl u_ctrl (
      .clk_in     (clk_in),
      .srst       (srst),
      .tx_req     (tx_req),
      .tx_dv      (tx_dv),
      .tx_dfr     (tx_dfr),
      .fifo_cnt   (fifo_cnt),
      .fifo_empty (tx_fifo_empty),
      .hdr        (hdr_if.dst),
      .first_req  (first_req),
      .tx_ack     (tx_ack),
      .tx_ws      (tx_ws),
      .data_take  (data_take)
   );

   tx_hdr_decode u_decode (
      .clk_in    (clk_in),
      .srst      (srst),
      .first_req (first_req),
      .tx_desc   (tx_desc),
      .hdr       (hdr_if.src)
   );

   tx_beat_packer u_packer (
      .clk_in    (clk_in),
      .first_req (first_req),
      .tx_ack    (tx_ack),
      .data_take (data_take),
      .tx_dfr    (tx_dfr),
      .tx_err    (tx_err),
      .tx_desc   (tx_desc),
      .tx_data   (tx_data),
      .hdr       (hdr_if.dst),
      .beat      (beat_if.src)
   );

   // ----------------------------------------------------------------------
   // buffer and link side
   // ----------------------------------------------------------------------
   tx_beat_fifo u_fifo (
      .clk_in (clk_in),
      .srst   (srst),
      .beat   (beat_if.dst),
      .rd     (fifo_rd),
      .q      (fifo_q),
      .empty  (tx_fifo_empty),
      .cnt    (fifo_cnt)
   );

   tx_stream_out u_out (
      .clk_in          (clk_in),
      .srst            (srst),
      .q               (fifo_q),
      .empty           (tx_fifo_empty),
      .rd              (fifo_rd),
      .tx_stream_ready (tx_stream_ready),
      .tx_stream_data  (tx_stream_data),
      .tx_stream_sop   (tx_stream_sop),
      .tx_stream_eop   (tx_stream_eop),
      .tx_stream_err   (tx_stream_err),
      .tx_stream_valid (tx_stream_valid)
   );

endmodule

//--- testbench/tb_tx_ref.svh
// Expected beat model
`ifndef TB_TX_REF_SVH
`define TB_TX_REF_SVH

typedef data_t word_list_t[$];
typedef beat_t beat_list_t[$];

// stored beat layout is {err, sop, eop, data}
function automatic beat_t pack_beat(input data_t d, input logic sop, input logic eop,
                                    input logic err);
   beat_t b;
   b           = '0;
   b[DATA_W-1:0] = d;
   b[BEAT_SOP] = sop;
   b[BEAT_EOP] = eop;
   b[BEAT_ERR] = err;
   return b;
endfunction

// full beat list of one packet, in link order
function automatic beat_list_t expected_beats(input desc_t desc, input word_list_t words,
                                              input logic err);
   beat_list_t         beats;
   data_t              dq[$];
   logic               four_dw;
   logic               payload;
   logic [QW_BITS-1:0] addr_lo;
   logic               merged;
   int                 first;
   int                 k;
   four_dw = desc[FMT_4DW_BIT];
   payload = desc[FMT_PAYLOAD_BIT];
   // address low bits sit in the last header dword
   if (four_dw) begin
      addr_lo = desc[ADDR4_LSB +: QW_BITS];
   end else begin
      addr_lo = desc[ADDR3_LSB +: QW_BITS];
   end
   merged = !four_dw && (addr_lo != '0) && payload && (words.size() > 0);
   // header dwords 0 and 1
   dq.push_back(desc[127:64]);
   if (merged) begin
      // dword 2, then the upper dword of word 0, which is used up
      dq.push_back({desc[63:32], words[0][63:32]});
      first = 1;
   end else begin
      dq.push_back(desc[63:0]);
      first = 0;
   end
   // remaining words go out with dwords swapped
   if (payload) begin
      for (k = first; k < words.size(); k++) begin
         dq.push_back({words[k][31:0], words[k][63:32]});
      end
   end
   for (k = 0; k < dq.size(); k++) begin
      beats.push_back(pack_beat(dq[k], k == 0, k == dq.size() - 1, err));
   end
   return beats;
endfunction

`endif

//--- testbench/tb_tx_pack.sv
// Transmit packer testbench
`timescale 1ns/1ns

module tb_tx_pack;
   import tx_pack_pkg::*;

   localparam int WAIT_LIMIT  = 1000;
   localparam int DRAIN_LIMIT = 4000;
   localparam int RAND_PKTS   = 80;

   logic  clk_in;
   logic  srst;
   logic  tx_req;
   logic  tx_ack;
   desc_t tx_desc;
   logic  tx_ws;
   logic  tx_err;
   logic  tx_dv;
   logic  tx_dfr;
   data_t tx_data;
   logic  tx_stream_ready;
   data_t tx_stream_data;
   logic  tx_stream_sop;
   logic  tx_stream_eop;
   logic  tx_stream_err;
   logic  tx_stream_valid;
   logic  tx_fifo_empty;

   // main process counters
   int    errors = 0;
   int    pkt_cnt = 0;
   int    throttle_cycles = 0;
   // monitor counters
   int    mon_errors = 0;
   int    beats_checked = 0;
   // back-pressure control written by the main process only
   bit    bp_random = 1'b0;
   int    stall_len = 0;
   int    stall_req_id = 0;

   // beats still to appear on the link with the oldest first
   beat_t exp_q[$];

   `include "tb_tx_ref.svh"

   tx_pack_top UUT (
      .clk_in          (clk_in),
      .srst            (srst),
      .tx_req          (tx_req),
      .tx_ack          (tx_ack),
      .tx_desc         (tx_desc),
      .tx_ws           (tx_ws),
      .tx_err          (tx_err),
      .tx_dv           (tx_dv),
      .tx_dfr          (tx_dfr),
      .tx_data         (tx_data),
      .tx_stream_ready (tx_stream_ready),
      .tx_stream_data  (tx_stream_data),
      .tx_stream_sop   (tx_stream_sop),
      .tx_stream_eop   (tx_stream_eop),
      .tx_stream_err   (tx_stream_err),
      .tx_stream_valid (tx_stream_valid),
      .tx_fifo_empty   (tx_fifo_empty)
   );

   // 40 ns clock
   initial begin
      clk_in = 1'b0;
      forever #20 clk_in = ~clk_in;
   end

   function automatic int check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[ERROR] %s got %h expected %h", name, got, exp);
         return 1;
      end
      return 0;
   endfunction

   function automatic desc_t make_desc(input bit four_dw, input bit payload, input bit aligned,
                                       input int nwords);
      desc_t   d;
      dw_len_t len;
      d = {$urandom, $urandom, $urandom, $urandom};
      d[FMT_PAYLOAD_BIT] = payload;
      d[FMT_4DW_BIT]     = four_dw;
      // word 0 of a merged header carries one dword only so the count is odd
      if (four_dw || aligned) begin
         len = dw_len_t'(2 * nwords);
      end else begin
         len = dw_len_t'(2 * nwords - 1);
      end
      if (payload) begin
         d[LEN_LSB +: LEN_W] = len;
      end
      if (four_dw) begin
         d[ADDR4_LSB +: QW_BITS] = aligned ? '0 : QW_BITS'($urandom_range(1, 7));
      end else begin
         d[ADDR3_LSB +: QW_BITS] = aligned ? '0 : QW_BITS'($urandom_range(1, 7));
      end
      return d;
   endfunction

   // ----------------------------------------------------------------------
   // one packet with request, ack and payload words with random dv gaps
   // ----------------------------------------------------------------------
   task automatic send_packet(input bit four_dw, input bit payload, input bit aligned,
                              input int nwords, input bit err_flag, output bit ok);
      desc_t      desc;
      word_list_t words;
      beat_list_t exp_beats;
      bit         merged;
      bit         acked;
      bit         ack_seen;
      bit         take;
      bit         held;
      int         idx;
      int         wait_cnt;
      int         k;
      desc   = make_desc(four_dw, payload, aligned, nwords);
      merged = !four_dw && !aligned && payload;
      for (k = 0; k < nwords; k++) begin
         words.push_back({$urandom, $urandom});
      end
      exp_beats = expected_beats(desc, words, err_flag);
      for (k = 0; k < exp_beats.size(); k++) begin
         exp_q.push_back(exp_beats[k]);
      end
      pkt_cnt++;
      acked    = 1'b0;
      idx      = 0;
      wait_cnt = 0;
      @(posedge clk_in);
      tx_req  <= 1'b1;
      tx_desc <= desc;
      tx_err  <= err_flag;
      tx_dfr  <= (nwords > 1);
      // merged header may offer word 0 with the request
      if (merged) begin
         tx_dv   <= ($urandom_range(0, 3) != 0);
         tx_data <= words[0];
      end else begin
         tx_dv <= 1'b0;
      end
      while (!(acked && idx >= nwords) && wait_cnt < WAIT_LIMIT) begin
         @(negedge clk_in);
         ack_seen = tx_ack;
         take     = tx_dv && !tx_ws;
         held     = tx_dv && tx_ws;
         // wait state in the payload phase is the almost-full throttle
         if (acked && idx < nwords && tx_ws) begin
            throttle_cycles++;
         end
         @(posedge clk_in);
         if (ack_seen) begin
            acked = 1'b1;
            tx_req <= 1'b0;
         end
         if (take) begin
            idx++;
         end
         if (ack_seen || take) begin
            wait_cnt = 0;
         end else begin
            wait_cnt++;
         end
         // a word offered under wait state stays put
         if (!held) begin
            if (idx < nwords && (acked || merged)) begin
               tx_dv   <= ($urandom_range(0, 3) != 0);
               tx_data <= words[idx];
               tx_dfr  <= (idx != nwords - 1);
            end else begin
               tx_dv <= 1'b0;
            end
         end
      end
      ok = 1'b1;
      if (wait_cnt >= WAIT_LIMIT) begin
         errors++;
         ok = 1'b0;
         if (!acked) begin
            $display("timeout: tx_ack never came for packet %0d", pkt_cnt);
         end else begin
            $display("timeout: word %0d of packet %0d was never accepted", idx, pkt_cnt);
         end
      end
   endtask

   // ----------------------------------------------------------------------
   // link back-pressure
   // ----------------------------------------------------------------------
   initial begin : ready_drive
      int hold;
      int seen_id;
      hold    = 0;
      seen_id = 0;
      tx_stream_ready <= 1'b0;
      forever begin
         @(posedge clk_in);
         if (stall_req_id != seen_id) begin
            seen_id = stall_req_id;
            hold    = stall_len;
         end
         if (hold > 0) begin
            hold--;
            tx_stream_ready <= 1'b0;
         end else if (bp_random) begin
            // rare long stall that pushes the FIFO past almost full
            if ($urandom_range(0, 99) < 2) begin
               hold = int'($urandom_range(40, 100));
               tx_stream_ready <= 1'b0;
            end else begin
               tx_stream_ready <= ($urandom_range(0, 3) != 0);
            end
         end else begin
            tx_stream_ready <= 1'b1;
         end
      end
   end

   // compare every consumed link beat with the expected list
   initial begin : link_monitor
      beat_t exp_beat;
      forever begin
         @(negedge clk_in);
         if (!srst && tx_stream_valid && tx_stream_ready) begin
            if (exp_q.size() == 0) begin
               mon_errors++;
               $display("unexpected beat on the link with no packet outstanding");
            end else begin
               exp_beat = exp_q.pop_front();
               if (tx_stream_data !== exp_beat[DATA_W-1:0]) begin
                  mon_errors++;
                  $display("[ERROR] tx_stream_data got %h expected %h",
                           tx_stream_data, exp_beat[DATA_W-1:0]);
               end
               mon_errors += check_bit("tx_stream_sop", tx_stream_sop, exp_beat[BEAT_SOP]);
               mon_errors += check_bit("tx_stream_eop", tx_stream_eop, exp_beat[BEAT_EOP]);
               mon_errors += check_bit("tx_stream_err", tx_stream_err, exp_beat[BEAT_ERR]);
               beats_checked++;
            end
         end
      end
   end

   // ----------------------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------------------
   initial begin : main_seq
      bit run_ok;
      bit ok;
      int n;
      int p;
      int wait_cnt;
      void'($urandom(7));
      srst    <= 1'b1;
      tx_req  <= 1'b0;
      tx_desc <= '0;
      tx_err  <= 1'b0;
      tx_dv   <= 1'b0;
      tx_dfr  <= 1'b0;
      tx_data <= '0;
      run_ok  = 1'b1;
      repeat (3) @(posedge clk_in);
      srst <= 1'b0;
      @(negedge clk_in);
      errors += check_bit("tx_ack", tx_ack, 1'b0);
      errors += check_bit("tx_ws", tx_ws, 1'b0);
      errors += check_bit("tx_stream_valid", tx_stream_valid, 1'b0);
      errors += check_bit("tx_fifo_empty", tx_fifo_empty, 1'b1);

      // dataless 3dw aligned and unaligned headers and a 4dw one
      send_packet(1'b0, 1'b0, 1'b1, 0, 1'b0, ok);
      run_ok &= ok;
      send_packet(1'b1, 1'b0, 1'b0, 0, 1'b0, ok);
      run_ok &= ok;
      send_packet(1'b0, 1'b0, 1'b0, 0, 1'b0, ok);
      run_ok &= ok;
      // payload headers of every kind with 1 to 8 words
      for (n = 1; n <= 8 && run_ok; n++) begin
         send_packet(1'b0, 1'b1, 1'b1, n, 1'b0, ok);
         run_ok &= ok;
         send_packet(1'b1, 1'b1, n[0], n, 1'b0, ok);
         run_ok &= ok;
         send_packet(1'b0, 1'b1, 1'b0, n, 1'b0, ok);
         run_ok &= ok;
      end
      // poisoned packets with the last one dataless
      for (n = 1; n <= 3 && run_ok; n++) begin
         send_packet(n == 2, n != 3, n == 1, (n == 3) ? 0 : n + 1, 1'b1, ok);
         run_ok &= ok;
      end

      // long stall with back-to-back large packets
      stall_len = 80;
      stall_req_id++;
      for (n = 0; n < 3 && run_ok; n++) begin
         send_packet(1'b1, 1'b1, 1'b1, 8, 1'b0, ok);
         run_ok &= ok;
      end
      if (run_ok && throttle_cycles == 0) begin
         errors++;
         $display("almost-full throttle never engaged during the long stall");
      end

      // random traffic under random back-pressure
      bp_random = 1'b1;
      for (p = 0; p < RAND_PKTS && run_ok; p++) begin
         n = int'($urandom_range(1, 8));
         if ($urandom_range(0, 4) == 0) begin
            n = 0;
         end
         send_packet($urandom_range(0, 1) == 1, n != 0, $urandom_range(0, 1) == 1, n,
                     $urandom_range(0, 4) == 0, ok);
         run_ok &= ok;
         repeat ($urandom_range(0, 2)) @(posedge clk_in);
      end

      // let the link drain
      wait_cnt = 0;
      while (exp_q.size() != 0 && wait_cnt < DRAIN_LIMIT) begin
         @(negedge clk_in);
         wait_cnt++;
      end
      if (exp_q.size() != 0) begin
         errors++;
         $display("timeout: %0d expected beats never appeared on the link", exp_q.size());
      end else begin
         repeat (4) @(negedge clk_in);
         errors += check_bit("tx_fifo_empty", tx_fifo_empty, 1'b1);
         errors += check_bit("tx_stream_valid", tx_stream_valid, 1'b0);
      end

      $display("summary: %0d packets, %0d beats checked, %0d errors",
               pkt_cnt, beats_checked, errors + mon_errors);
      if (errors + mon_errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

//--- vlog.f
+incdir+testbench
hw/tx_pack_pkg.sv
hw/tx_hdr_if.sv
hw/tx_beat_if.sv
hw/tx_req_ctrl.sv
hw/tx_hdr_decode.sv
hw/tx_beat_packer.sv
hw/tx_beat_fifo.sv
hw/tx_stream_out.sv
hw/tx_pack_top.sv
testbench/tb_tx_pack.sv

//--- run_sim.sh
#!/bin/sh
# build and run the transmit packer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_tx_pack \
   -Mdir obj_dir -o sim_tx_pack
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

./obj_dir/sim_tx_pack > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
   exit 0
fi
exit 1
